//--- design/periph_map_pkg.sv
// Peripheral address map
// Cluster base, peripheral window bounds, routing bits and the target index

`default_nettype none

package periph_map_pkg;

  localparam int NUM_TARG = 4;

  // Target index taken from the routing bits inside the window
  typedef enum logic [1:0] {
    TARG_EVENT_UNIT = 2'd0,
    TARG_TIMER      = 2'd1,
    TARG_DMA_CFG    = 2'd2,
    TARG_EXT        = 2'd3
  } target_e;

  // Compared against addr[31:24]
  localparam logic [7:0] CLUSTER_BASE = 8'h10;

  // Inclusive range of addr[23:20]
  localparam logic [3:0] PERIPH_WIN_LO = 4'h2;
  localparam logic [3:0] PERIPH_WIN_HI = 4'h3;

  localparam int ROUTE_LSB = 16;
  localparam int ROUTE_MSB = 17;

endpackage

`default_nettype wire

//--- design/periph_bus_pkg.sv
// Peripheral bus definitions
// Word widths, initiator count and the command, request and response
// structs carried between initiators and target peripherals

`default_nettype none

package periph_bus_pkg;

  localparam int NUM_INIT   = 4;
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int BE_W       = DATA_W / 8;
  localparam int INIT_IDX_W = $clog2(NUM_INIT);

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [BE_W-1:0]     be_t;
  // One bit per initiator
  typedef logic [NUM_INIT-1:0] init_id_t;

  // Issued by an initiator
  typedef struct packed {
    addr_t addr;
    data_t data;
    logic  we_n;  // low for a write
    be_t   be;
  } periph_cmd_t;

  // Command tagged with the requester as seen by a target
  typedef struct packed {
    periph_cmd_t cmd;
    init_id_t    id;
  } periph_req_t;

  typedef struct packed {
    data_t    data;
    init_id_t id;
    logic     opc;  // Error flag
  } periph_rsp_t;

endpackage

`default_nettype wire

//--- design/periph_init_port.sv
// Initiator port of the peripheral crossbar
// Decodes the request address to a target, raises one request line,
// returns that target's grant and picks out the response for this initiator

`timescale 1ns/1ps
`default_nettype none

module periph_init_port #(
  parameter int unsigned INIT_IDX = 0
) (
  // Initiator side
  input  logic                                                req_i,
  input  periph_bus_pkg::periph_cmd_t                         cmd_i,
  output logic                                                gnt_o,
  output logic                                                rvalid_o,
  output periph_bus_pkg::periph_rsp_t                         rsp_o,

  // Toward the target arbiters
  output logic [periph_map_pkg::NUM_TARG-1:0]                 targ_req_o,
  output periph_bus_pkg::periph_req_t                         targ_req_data_o,
  input  logic [periph_map_pkg::NUM_TARG-1:0]                 targ_gnt_i,

  // Responses from all targets
  input  logic [periph_map_pkg::NUM_TARG-1:0]                 targ_rvalid_i,
  input  periph_bus_pkg::periph_rsp_t [periph_map_pkg::NUM_TARG-1:0] targ_rsp_i
);

  periph_bus_pkg::init_id_t own_id;
  periph_map_pkg::target_e  targ_sel;
  logic                     in_window;

  assign own_id = periph_bus_pkg::init_id_t'(1) << INIT_IDX;

  // Address decode
  always_comb begin
    in_window = (cmd_i.addr[31:24] == periph_map_pkg::CLUSTER_BASE) &&
                (cmd_i.addr[23:20] >= periph_map_pkg::PERIPH_WIN_LO) &&
                (cmd_i.addr[23:20] <= periph_map_pkg::PERIPH_WIN_HI);
    if (in_window) begin
      targ_sel = periph_map_pkg::target_e'(
        cmd_i.addr[periph_map_pkg::ROUTE_MSB:periph_map_pkg::ROUTE_LSB]);
    end else begin
      // Anything outside the window leaves the cluster
      targ_sel = periph_map_pkg::TARG_EXT;
    end
  end

  // Request demux raising req toward the selected target only
  always_comb begin
    targ_req_o           = '0;
    targ_req_o[targ_sel] = req_i;
  end

  assign gnt_o = targ_gnt_i[targ_sel];

  // Same tagged command goes to every arbiter
  assign targ_req_data_o.cmd = cmd_i;
  assign targ_req_data_o.id  = own_id;

  // Response select
  // Targets never send two responses to one initiator in the same cycle
  always_comb begin
    rvalid_o = 1'b0;
    rsp_o    = '0;
    for (int t = 0; t < periph_map_pkg::NUM_TARG; t++) begin
      if (targ_rvalid_i[t] && (targ_rsp_i[t].id == own_id)) begin
        rvalid_o = 1'b1;
        rsp_o    = targ_rsp_i[t];
      end
    end
  end

endmodule

`default_nettype wire

//--- design/periph_rr_arbiter.sv
// Round-robin arbiter in front of one target peripheral
// Picks the first requester at or after the priority pointer, forwards its
// tagged request and grants it once the target accepts

`timescale 1ns/1ps
`default_nettype none

module periph_rr_arbiter (
  input  logic                                                       clk_i,
  input  logic                                                       rst_i,

  // From the initiator ports
  input  logic [periph_bus_pkg::NUM_INIT-1:0]                        req_i,
  input  periph_bus_pkg::periph_req_t [periph_bus_pkg::NUM_INIT-1:0] req_data_i,
  output logic [periph_bus_pkg::NUM_INIT-1:0]                        gnt_o,

  // Toward the target
  output logic                                                       targ_req_o,
  output periph_bus_pkg::periph_req_t                                targ_req_data_o,
  input  logic                                                       targ_gnt_i
);

  logic [periph_bus_pkg::INIT_IDX_W-1:0] ptr_q;
  logic [periph_bus_pkg::INIT_IDX_W-1:0] ptr_d;
  logic [periph_bus_pkg::INIT_IDX_W-1:0] win;
  logic                                  handshake;

  // Winner search starting at the pointer and wrapping around
  always_comb begin
    int unsigned idx;
    logic        found;
    found = 1'b0;
    win   = ptr_q;
    for (int unsigned k = 0; k < periph_bus_pkg::NUM_INIT; k++) begin
      idx = (int'(ptr_q) + k) % periph_bus_pkg::NUM_INIT;
      if (!found && req_i[idx]) begin
        found = 1'b1;
        win   = periph_bus_pkg::INIT_IDX_W'(idx);
      end
    end
  end

  assign targ_req_o      = |req_i;
  assign targ_req_data_o = req_data_i[win];
  assign handshake       = targ_req_o & targ_gnt_i;

  // Grant only the winner, and only when the target takes it
  always_comb begin
    gnt_o      = '0;
    gnt_o[win] = handshake;
  end

  // Next priority goes to the initiator after the one just served
  always_comb begin
    if (int'(win) == periph_bus_pkg::NUM_INIT - 1) begin
      ptr_d = '0;
    end else begin
      ptr_d = win + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (handshake) begin
      ptr_q <= ptr_d;
    end
  end

endmodule

`default_nettype wire

//--- design/periph_xbar.sv
// Peripheral crossbar
// Connects every initiator port to every target arbiter. Requests and
// responses pass combinationally and only the arbiter pointers are clocked

`timescale 1ns/1ps
`default_nettype none

module periph_xbar (
  input  logic                                                        clk_i,
  input  logic                                                        rst_i,

  // Initiators
  input  logic [periph_bus_pkg::NUM_INIT-1:0]                         init_req_i,
  input  periph_bus_pkg::periph_cmd_t [periph_bus_pkg::NUM_INIT-1:0]  init_cmd_i,
  output logic [periph_bus_pkg::NUM_INIT-1:0]                         init_gnt_o,
  output logic [periph_bus_pkg::NUM_INIT-1:0]                         init_rvalid_o,
  output periph_bus_pkg::periph_rsp_t [periph_bus_pkg::NUM_INIT-1:0]  init_rsp_o,

  // Targets
  output logic [periph_map_pkg::NUM_TARG-1:0]                         targ_req_o,
  output periph_bus_pkg::periph_req_t [periph_map_pkg::NUM_TARG-1:0]  targ_req_data_o,
  input  logic [periph_map_pkg::NUM_TARG-1:0]                         targ_gnt_i,
  input  logic [periph_map_pkg::NUM_TARG-1:0]                         targ_rvalid_i,
  input  periph_bus_pkg::periph_rsp_t [periph_map_pkg::NUM_TARG-1:0]  targ_rsp_i
);

  // Request and grant matrices in initiator-major and target-major order
  logic [periph_bus_pkg::NUM_INIT-1:0][periph_map_pkg::NUM_TARG-1:0] init_targ_req;
  logic [periph_bus_pkg::NUM_INIT-1:0][periph_map_pkg::NUM_TARG-1:0] init_targ_gnt;
  logic [periph_map_pkg::NUM_TARG-1:0][periph_bus_pkg::NUM_INIT-1:0] arb_req;
  logic [periph_map_pkg::NUM_TARG-1:0][periph_bus_pkg::NUM_INIT-1:0] arb_gnt;

  periph_bus_pkg::periph_req_t [periph_bus_pkg::NUM_INIT-1:0] tagged_req;

  for (genvar i = 0; i < periph_bus_pkg::NUM_INIT; i++) begin : gen_init
    periph_init_port #(
      .INIT_IDX (i)
    ) i_init_port (
      .req_i           (init_req_i[i]),
      .cmd_i           (init_cmd_i[i]),
      .gnt_o           (init_gnt_o[i]),
      .rvalid_o        (init_rvalid_o[i]),
      .rsp_o           (init_rsp_o[i]),
      .targ_req_o      (init_targ_req[i]),
      .targ_req_data_o (tagged_req[i]),
      .targ_gnt_i      (init_targ_gnt[i]),
      .targ_rvalid_i   (targ_rvalid_i),
      .targ_rsp_i      (targ_rsp_i)
    );
  end

  // Transpose
  for (genvar t = 0; t < periph_map_pkg::NUM_TARG; t++) begin : gen_transpose
    for (genvar i = 0; i < periph_bus_pkg::NUM_INIT; i++) begin : gen_bit
      assign arb_req[t][i]       = init_targ_req[i][t];
      assign init_targ_gnt[i][t] = arb_gnt[t][i];
    end
  end

  for (genvar t = 0; t < periph_map_pkg::NUM_TARG; t++) begin : gen_targ
    periph_rr_arbiter i_arb (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .req_i           (arb_req[t]),
      .req_data_i      (tagged_req),
      .gnt_o           (arb_gnt[t]),
      .targ_req_o      (targ_req_o[t]),
      .targ_req_data_o (targ_req_data_o[t]),
      .targ_gnt_i      (targ_gnt_i[t])
    );
  end

endmodule

`default_nettype wire

//--- verification/periph_target_model.sv
// Behavioral target peripheral
// Grants while gnt_mode_i is high and answers each accepted request one
// cycle later with the address XOR its own index in every byte

`timescale 1ns/1ps
`default_nettype none

module periph_target_model #(
  parameter int unsigned TARG_IDX = 0
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        gnt_mode_i,
  input  logic                        req_i,
  input  periph_bus_pkg::periph_req_t req_data_i,
  output logic                        gnt_o,
  output logic                        rvalid_o,
  output periph_bus_pkg::periph_rsp_t rsp_o
);

  // Low mode stalls every request
  assign gnt_o = gnt_mode_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_o <= 1'b0;
      rsp_o    <= '0;
    end else begin
      rvalid_o   <= req_i & gnt_o;
      rsp_o.data <= req_data_i.cmd.addr ^ {periph_bus_pkg::BE_W{8'(TARG_IDX)}};
      rsp_o.id   <= req_data_i.id;
      rsp_o.opc  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- verification/periph_xbar_tb.sv
// Testbench for the peripheral crossbar
// Four target models answer requests; a checker compares every handshake
// and response against the address map and the target data rule

`timescale 1ns/1ps
`default_nettype none

module periph_xbar_tb;

  localparam int          NI         = periph_bus_pkg::NUM_INIT;
  localparam int          NT         = periph_map_pkg::NUM_TARG;
  localparam int          CLK_PERIOD = 100;
  localparam int          DRIVE_DLY  = 5;
  localparam int          TIMEOUT    = 200;
  localparam logic [31:0] SEED       = 32'hfc1c_98cb;

  logic        clk;
  logic        rst;
  logic [31:0] lfsr;

  logic [NI-1:0]                        init_req;
  periph_bus_pkg::periph_cmd_t [NI-1:0] init_cmd;
  logic [NI-1:0]                        init_gnt;
  logic [NI-1:0]                        init_rvalid;
  periph_bus_pkg::periph_rsp_t [NI-1:0] init_rsp;
  logic [NT-1:0]                        targ_req;
  periph_bus_pkg::periph_req_t [NT-1:0] targ_req_data;
  logic [NT-1:0]                        targ_gnt;
  logic [NT-1:0]                        targ_rvalid;
  periph_bus_pkg::periph_rsp_t [NT-1:0] targ_rsp;
  logic [NT-1:0]                        gnt_mode;

  // Checker state
  periph_bus_pkg::data_t       exp_rsp [NI][$];
  int                          accepted [NI];
  periph_bus_pkg::init_id_t    seen [NT][NI];
  periph_bus_pkg::periph_req_t held_req [NT];
  logic [NT-1:0]               stall_q;

  always #(CLK_PERIOD / 2) clk = ~clk;

  periph_xbar UUT (
    .clk_i           (clk),
    .rst_i           (rst),
    .init_req_i      (init_req),
    .init_cmd_i      (init_cmd),
    .init_gnt_o      (init_gnt),
    .init_rvalid_o   (init_rvalid),
    .init_rsp_o      (init_rsp),
    .targ_req_o      (targ_req),
    .targ_req_data_o (targ_req_data),
    .targ_gnt_i      (targ_gnt),
    .targ_rvalid_i   (targ_rvalid),
    .targ_rsp_i      (targ_rsp)
  );

  for (genvar t = 0; t < NT; t++) begin : gen_targ
    periph_target_model #(
      .TARG_IDX (t)
    ) i_targ (
      .clk_i      (clk),
      .rst_i      (rst),
      .gnt_mode_i (gnt_mode[t]),
      .req_i      (targ_req[t]),
      .req_data_i (targ_req_data[t]),
      .gnt_o      (targ_gnt[t]),
      .rvalid_o   (targ_rvalid[t]),
      .rsp_o      (targ_rsp[t])
    );
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // Expected target from the address map
  function automatic int expected_target(input periph_bus_pkg::addr_t addr);
    if (addr[31:24] == periph_map_pkg::CLUSTER_BASE &&
        addr[23:20] >= periph_map_pkg::PERIPH_WIN_LO &&
        addr[23:20] <= periph_map_pkg::PERIPH_WIN_HI) begin
      return int'(addr[periph_map_pkg::ROUTE_MSB:periph_map_pkg::ROUTE_LSB]);
    end
    return int'(periph_map_pkg::TARG_EXT);
  endfunction

  // Expected read data from target t
  function automatic periph_bus_pkg::data_t expected_rdata(input periph_bus_pkg::addr_t addr,
                                                           input int t);
    return addr ^ {periph_bus_pkg::BE_W{8'(t)}};
  endfunction

  function automatic int outstanding();
    int n;
    n = 0;
    for (int i = 0; i < NI; i++) begin
      n += exp_rsp[i].size();
    end
    return n;
  endfunction

  function automatic periph_bus_pkg::periph_cmd_t make_cmd(input logic [31:0] addr,
                                                           input logic [31:0] data);
    periph_bus_pkg::periph_cmd_t cmd;
    cmd.addr = addr;
    cmd.data = data;
    cmd.we_n = 1'b0;
    cmd.be   = '1;
    return cmd;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [79:0] got, input logic [79:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("ERR %0t %s got %0h expected %0h", $time, name, got, exp));
    end
  endtask

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // Half the addresses land in the peripheral window
  task automatic random_cmd(output periph_bus_pkg::periph_cmd_t cmd);
    logic [31:0] bits;
    rand_bits(1, bits);
    if (bits[0]) begin
      rand_bits(21, bits);
      cmd.addr = {periph_map_pkg::CLUSTER_BASE, 3'b001, bits[20:0]};
    end else begin
      rand_bits(32, bits);
      cmd.addr = bits;
    end
    rand_bits(32, bits);
    cmd.data = bits;
    rand_bits(5, bits);
    cmd.we_n = bits[4];
    cmd.be   = bits[3:0];
  endtask

  task automatic issue(input int i, input periph_bus_pkg::periph_cmd_t cmd);
    int waited;
    waited = 0;
    @(posedge clk);
    #DRIVE_DLY;
    init_req[i] = 1'b1;
    init_cmd[i] = cmd;
    @(negedge clk);
    while (!init_gnt[i]) begin
      waited++;
      if (waited > TIMEOUT) begin
        stop_run($sformatf("initiator %0d was never granted", i));
      end
      @(negedge clk);
    end
    @(posedge clk);
    #DRIVE_DLY;
    init_req[i] = 1'b0;
  endtask

  task automatic issue_set(input periph_bus_pkg::periph_cmd_t [NI-1:0] cmds);
    fork
      issue(0, cmds[0]);
      issue(1, cmds[1]);
      issue(2, cmds[2]);
      issue(3, cmds[3]);
    join
  endtask

  // Back-to-back requests to the timer
  task automatic issue_burst(input int i, input int n);
    for (int r = 0; r < n; r++) begin
      issue(i, make_cmd(32'h1021_0000 | (i << 8) | r, 32'(r)));
    end
  endtask

  // Comparison process sampling settled outputs at the falling edge
  always @(negedge clk) begin
    periph_bus_pkg::periph_req_t exp_req;
    periph_bus_pkg::init_id_t    want [NT];
    periph_bus_pkg::init_id_t    won;
    int                          t;
    if (rst) begin
      for (int i = 0; i < NI; i++) begin
        exp_rsp[i].delete();
        accepted[i] = 0;
        for (int k = 0; k < NT; k++) begin
          seen[k][i] = '0;
        end
      end
      stall_q = '0;
    end else begin
      for (int i = 0; i < NI; i++) begin
        if (init_rvalid[i] && exp_rsp[i].size() == 0) begin
          stop_run($sformatf("initiator %0d got a response it never asked for", i));
        end else if (init_rvalid[i]) begin
          check_value("init_rsp_o.data", init_rsp[i].data, exp_rsp[i].pop_front());
          check_value("init_rsp_o.id", init_rsp[i].id, 1 << i);
          check_value("init_rsp_o.opc", init_rsp[i].opc, 0);
        end
      end
      for (int k = 0; k < NT; k++) begin
        want[k] = '0;
      end
      for (int i = 0; i < NI; i++) begin
        if (init_req[i]) begin
          t          = expected_target(init_cmd[i].addr);
          want[t][i] = 1'b1;
          if (init_gnt[i]) begin
            exp_req.cmd = init_cmd[i];
            exp_req.id  = periph_bus_pkg::init_id_t'(1) << i;
            check_value("targ_gnt_i", targ_gnt[t], 1);
            check_value("targ_req_data_o", targ_req_data[t], exp_req);
            exp_rsp[i].push_back(expected_rdata(init_cmd[i].addr, t));
            accepted[i]++;
          end
        end
      end
      // Idle initiators are never granted
      check_value("init_gnt_o", init_gnt & ~init_req, 0);
      for (int k = 0; k < NT; k++) begin
        won = (targ_req[k] && targ_gnt[k]) ? targ_req_data[k].id : '0;
        check_value("targ_req_o", targ_req[k], |want[k]);
        check_value("init_gnt_o", init_gnt & want[k], won);
        if (stall_q[k] && targ_req[k]) begin
          check_value("targ_req_data_o", targ_req_data[k], held_req[k]);
        end
        stall_q[k]  = targ_req[k] && !targ_gnt[k];
        held_req[k] = targ_req_data[k];
        // Winners seen by each initiator still waiting on this target
        for (int j = 0; j < NI; j++) begin
          if (!want[k][j] || won[j]) begin
            seen[k][j] = '0;
          end else if ((seen[k][j] & won) != 0) begin
            stop_run($sformatf("target %0d granted initiator %0d twice while %0d waited",
                               k, $clog2(won), j));
          end else begin
            seen[k][j] |= won;
          end
        end
      end
    end
  end

  initial begin
    periph_bus_pkg::periph_cmd_t [NI-1:0] cmds;
    int                                   base [NI];
    int                                   waited;
    clk      = 1'b0;
    rst      = 1'b1;
    init_req = '0;
    init_cmd = '0;
    gnt_mode = '1;
    lfsr     = SEED;
    repeat (4) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;

    @(negedge clk);
    check_value("init_gnt_o", init_gnt, 0);
    check_value("init_rvalid_o", init_rvalid, 0);
    check_value("targ_req_o", targ_req, 0);

    // Everyone hammers the timer
    fork
      issue_burst(0, 3);
      issue_burst(1, 3);
      issue_burst(2, 3);
      issue_burst(3, 3);
    join

    // Timer stalled while event unit and external target keep going
    cmds[0] = make_cmd(32'h1031_0040, 32'h0000_aaaa);
    cmds[1] = make_cmd(32'h1021_0080, 32'h0000_bbbb);
    cmds[2] = make_cmd(32'h1020_0010, 32'h0000_cccc);
    cmds[3] = make_cmd(32'h1040_0000, 32'h0000_dddd);
    @(posedge clk);
    #DRIVE_DLY;
    gnt_mode[periph_map_pkg::TARG_TIMER] = 1'b0;
    base = accepted;
    fork
      issue_set(cmds);
      begin
        repeat (6) @(negedge clk);
        @(posedge clk);
        check_value("accepted[0]", accepted[0], base[0]);
        check_value("accepted[1]", accepted[1], base[1]);
        check_value("accepted[2]", accepted[2], base[2] + 1);
        check_value("accepted[3]", accepted[3], base[3] + 1);
        #DRIVE_DLY;
        gnt_mode[periph_map_pkg::TARG_TIMER] = 1'b1;
      end
    join

    for (int r = 0; r < 24; r++) begin
      for (int i = 0; i < NI; i++) begin
        random_cmd(cmds[i]);
      end
      issue_set(cmds);
    end

    waited = 0;
    while (outstanding() != 0 && waited < TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (outstanding() != 0) begin
      stop_run("responses still missing when the run ended");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- tb.f
design/periph_map_pkg.sv
design/periph_bus_pkg.sv
design/periph_init_port.sv
design/periph_rr_arbiter.sv
design/periph_xbar.sv
verification/periph_target_model.sv
verification/periph_xbar_tb.sv

//--- Makefile
# Verilator build and run of the peripheral crossbar testbench

TOP := periph_xbar_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary -Wno-fatal -f tb.f --top-module $(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
